//--- vlog.f
hw/link_pkg.sv
hw/credit_pkg.sv
hw/credit_sender.sv
hw/credit_receiver.sv
hw/rx_fifo.sv
hw/packet_summer.sv
hw/credit_link_top.sv
tb/tb_clock_gen.sv
tb/credit_link_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = credit_link_tb
FILELIST = vlog.f
LOG      = sim.log
OBJ      = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ) $(LOG)

//--- tb/credit_link_tb.sv
// Credit link testbench

`default_nettype none

module credit_link_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PKTS     = 8;
  localparam int SEND_TIMEOUT = 2000;
  localparam int WAIT_TIMEOUT = 5000;

  // Packet table: length and start byte of each packet.
  localparam int PKT_LEN [NUM_PKTS]   = '{3, 1, 5, 2, 4, 6, 1, 8};
  localparam int PKT_START [NUM_PKTS] = '{16, 200, 254, 7, 128, 250, 99, 1};

  logic                         clk;
  logic                         rst;
  logic                         rst_req;
  logic                         src_valid;
  link_pkg::flit_t              src_flit;
  logic                         src_stall;
  logic                         credit_stall;
  logic [credit_pkg::CNT_W-1:0] credit_initial;
  logic [credit_pkg::CNT_W-1:0] credit_withhold;
  logic                         sink_stall;
  logic                         sum_valid;
  link_pkg::pkt_result_t        result;
  logic [credit_pkg::CNT_W-1:0] credit_count;
  logic [credit_pkg::CNT_W-1:0] credit_available;

  link_pkg::flit_t       src_q [$];
  link_pkg::pkt_result_t exp_q [$];

  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          failed_tests = 0;
  int          taken = 0;
  int          results_seen = 0;
  bit          stop_send = 1'b0;
  logic [31:0] rng_stall = 32'd88088;
  logic [31:0] rng_gap = 32'd88088;

  tb_clock_gen tb_clock_gen_i (
    .clk     (clk),
    .rst     (rst),
    .rst_req (rst_req)
  );

  credit_link_top credit_link_top_i (
    .clk              (clk),
    .rst              (rst),
    .src_valid        (src_valid),
    .src_flit         (src_flit),
    .src_stall        (src_stall),
    .credit_stall     (credit_stall),
    .credit_initial   (credit_initial),
    .credit_withhold  (credit_withhold),
    .sink_stall       (sink_stall),
    .sum_valid        (sum_valid),
    .result           (result),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input string msg, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR @%0t: %s got %0d expected %0d", $time, msg, got, exp);
    end
  endtask

  // Results are sampled on the falling edge, where the registered outputs are settled.
  always @(negedge clk) begin
    if (!rst && sum_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Unexpected packet result at time %0t with nothing outstanding", $time);
      end else begin
        check_value("result sum", int'(result.sum), int'(exp_q[0].sum));
        check_value("result len", int'(result.len), int'(exp_q[0].len));
        void'(exp_q.pop_front());
        results_seen++;
      end
    end
  end

  task automatic apply_reset(input int init, input int withhold);
    int n;
    n = 0;
    @(negedge clk);
    src_valid    = 1'b0;
    sink_stall   = 1'b1;
    credit_stall = 1'b0;
    rst_req      = 1'b1;
    @(negedge clk);
    // Credit limits only change while the link is held in reset.
    credit_initial  = 4'(init);
    credit_withhold = 4'(withhold);
    rst_req         = 1'b0;
    while (rst && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (rst) begin
      errors++;
      $display("Timeout: reset never released");
    end
    src_q.delete();
    exp_q.delete();
    taken        = 0;
    results_seen = 0;
    stop_send    = 1'b0;
  endtask

  // Turns the packet table into source flits and expected results.
  task automatic load_table();
    link_pkg::flit_t       f;
    link_pkg::pkt_result_t r;
    int                    sum;
    for (int p = 0; p < NUM_PKTS; p++) begin
      sum = 0;
      for (int i = 0; i < PKT_LEN[p]; i++) begin
        f.data = 8'((PKT_START[p] + i) % 256);
        f.op   = (i == PKT_LEN[p] - 1) ? link_pkg::FLIT_END : link_pkg::FLIT_BODY;
        src_q.push_back(f);
        sum += (PKT_START[p] + i) % 256;
      end
      r.sum = 16'(sum);
      r.len = 8'(PKT_LEN[p]);
      exp_q.push_back(r);
    end
  endtask

  // A flit shown with src_stall low at the falling edge is taken on the next rising edge.
  task automatic send_flits(input bit gaps);
    int wait_cnt;
    wait_cnt = 0;
    forever begin
      @(negedge clk);
      if (src_q.size() == 0 || stop_send) begin
        break;
      end
      if (gaps) begin
        rng_gap = xorshift(rng_gap);
      end
      if (gaps && rng_gap[1:0] == 2'b00) begin
        src_valid = 1'b0;
        wait_cnt++;
      end else begin
        src_valid = 1'b1;
        src_flit  = src_q[0];
        if (!src_stall) begin
          void'(src_q.pop_front());
          taken++;
          wait_cnt = 0;
        end else begin
          wait_cnt++;
        end
      end
      if (wait_cnt >= SEND_TIMEOUT) begin
        errors++;
        $display("Timeout: source flit was never accepted at time %0t", $time);
        src_q.delete();
      end
    end
    src_valid = 1'b0;
  endtask

  task automatic wait_results(input string what);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("Timeout: %s is still missing %0d packet results", what, exp_q.size());
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors != err_before) begin
      failed_tests++;
      $display("Test %0d %s: failed", tests, name);
    end else begin
      $display("Test %0d %s: ok", tests, name);
    end
  endtask

  initial begin
    int err_before;
    int n;
    int done_pkts;
    int flits;
    link_pkg::flit_t f;
    rst_req         = 1'b0;
    src_valid       = 1'b0;
    src_flit        = '0;
    credit_stall    = 1'b0;
    credit_initial  = 4'd8;
    credit_withhold = 4'd0;
    sink_stall      = 1'b1;

    // The sender may only ever hold the initial credits while nothing drains.
    err_before = errors;
    apply_reset(5, 0);
    f = '{op: link_pkg::FLIT_END, data: 8'h5a};
    for (int i = 0; i < 20; i++) begin
      src_q.push_back(f);
    end
    fork
      send_flits(1'b0);
      begin
        repeat (40) @(negedge clk);
        stop_send = 1'b1;
      end
    join
    check_value("initial credit flits taken", taken, 5);
    check_value("initial credit src_stall", int'(src_stall), 1);
    check_value("initial credit count", int'(credit_count), 5);
    report_test("initial credit", err_before);

    err_before = errors;
    apply_reset(6, 2);
    for (int i = 0; i < 20; i++) begin
      src_q.push_back(f);
    end
    fork
      send_flits(1'b0);
      begin
        repeat (40) @(negedge clk);
        stop_send = 1'b1;
      end
    join
    check_value("withhold flits taken", taken, 4);
    check_value("withhold credit count", int'(credit_count), 4);
    check_value("withhold credit available", int'(credit_available), 0);
    report_test("withhold", err_before);

    err_before = errors;
    apply_reset(8, 0);
    sink_stall = 1'b0;
    load_table();
    fork
      send_flits(1'b0);
      wait_results("packet sums");
    join
    check_value("packet sums results", results_seen, NUM_PKTS);
    report_test("packet sums", err_before);

    err_before = errors;
    apply_reset(8, 0);
    n = 0;
    while (int'(credit_count) != 8 && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (int'(credit_count) != 8) begin
      errors++;
      $display("Timeout: initial credits were never granted");
    end
    credit_stall = 1'b1;
    sink_stall   = 1'b0;
    load_table();
    fork
      send_flits(1'b0);
      begin
        n = 0;
        while (!(src_stall && taken == 8) && n < 200) begin
          @(negedge clk);
          n++;
        end
        if (!(src_stall && taken == 8)) begin
          errors++;
          $display("Timeout: sender never ran out of credit under credit stall");
        end
        repeat (20) begin
          @(negedge clk);
          check_value("credit stall src_stall", int'(src_stall), 1);
        end
        check_value("credit stall flits taken", taken, 8);
        // Only packets that fit wholly in the first eight flits can finish.
        done_pkts = 0;
        flits = 0;
        for (int p = 0; p < NUM_PKTS; p++) begin
          flits += PKT_LEN[p];
          if (flits <= 8) begin
            done_pkts++;
          end
        end
        check_value("credit stall drained results", results_seen, done_pkts);
        credit_stall = 1'b0;
        wait_results("credit stall");
      end
    join
    check_value("credit stall results", results_seen, NUM_PKTS);
    report_test("credit stall", err_before);

    err_before = errors;
    apply_reset(7, 1);
    load_table();
    fork
      send_flits(1'b1);
      begin
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_TIMEOUT) begin
          @(negedge clk);
          rng_stall  = xorshift(rng_stall);
          sink_stall = rng_stall[0];
          n++;
        end
        @(negedge clk);
        sink_stall = 1'b0;
      end
    join
    wait_results("random back-pressure");
    // Once idle, every credit is back with the sender.
    n = 0;
    while (int'(credit_count) != 6 && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (int'(credit_count) != 6) begin
      errors++;
      $display("Timeout: credits never settled after the random traffic");
    end
    check_value("random results", results_seen, NUM_PKTS);
    check_value("random final credit count", int'(credit_count), 6);
    check_value("random final credit available", int'(credit_available), 0);
    report_test("random back-pressure", err_before);

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0 && failed_tests == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Guard against a stuck run.
  initial begin
    #2ms;
    $display("Simulation ran too long and was stopped");
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
// Testbench clock and reset

`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst,
  input  logic rst_req
);

  timeunit 1ns;
  timeprecision 1ps;

  // Reset is held for 16 rising edges after power-up or after a request.
  logic [4:0] rst_cnt = 5'd16;

  initial begin
    clk = 1'b0;
    rst = 1'b1;
  end

  always #5 clk = ~clk;

  always @(posedge clk) begin
    if (rst_req) begin
      rst_cnt <= 5'd16;
      rst     <= 1'b1;
    end else if (rst_cnt != 5'd0) begin
      rst_cnt <= rst_cnt - 5'd1;
      if (rst_cnt == 5'd1) begin
        rst <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/credit_link_top.sv
// Credit link top level

`default_nettype none

module credit_link_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         src_valid,
  input  link_pkg::flit_t              src_flit,
  output logic                         src_stall,
  input  logic                         credit_stall,
  input  logic [credit_pkg::CNT_W-1:0] credit_initial,
  input  logic [credit_pkg::CNT_W-1:0] credit_withhold,
  input  logic                         sink_stall,
  output logic                         sum_valid,
  output link_pkg::pkt_result_t        result,
  output logic [credit_pkg::CNT_W-1:0] credit_count,
  output logic [credit_pkg::CNT_W-1:0] credit_available
);

  // Link between sender and receiver.
  logic            push_valid;
  link_pkg::flit_t push_flit;
  logic            push_credit;

  // Receive side buffer ports.
  logic            wr_valid;
  link_pkg::flit_t wr_flit;
  link_pkg::flit_t rd_flit;
  logic            empty;
  logic            pop;

  credit_sender credit_sender_i (
    .clk         (clk),
    .rst         (rst),
    .src_valid   (src_valid),
    .src_flit    (src_flit),
    .src_stall   (src_stall),
    .push_credit (push_credit),
    .push_valid  (push_valid),
    .push_flit   (push_flit)
  );

  // Each pop frees a FIFO entry and so doubles as the returned credit.
  credit_receiver credit_receiver_i (
    .clk              (clk),
    .rst              (rst),
    .push_valid       (push_valid),
    .push_flit        (push_flit),
    .push_credit      (push_credit),
    .credit_stall     (credit_stall),
    .credit_initial   (credit_initial),
    .credit_withhold  (credit_withhold),
    .pop_credit       (pop),
    .wr_valid         (wr_valid),
    .wr_flit          (wr_flit),
    .credit_count     (credit_count),
    .credit_available (credit_available)
  );

  rx_fifo rx_fifo_i (
    .clk      (clk),
    .rst      (rst),
    .wr_valid (wr_valid),
    .wr_flit  (wr_flit),
    .pop      (pop),
    .rd_flit  (rd_flit),
    .empty    (empty)
  );

  packet_summer packet_summer_i (
    .clk        (clk),
    .rst        (rst),
    .empty      (empty),
    .rd_flit    (rd_flit),
    .sink_stall (sink_stall),
    .pop        (pop),
    .sum_valid  (sum_valid),
    .result     (result)
  );

endmodule

`default_nettype wire

//--- hw/packet_summer.sv
// Packet summer

`default_nettype none

module packet_summer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  empty,
  input  link_pkg::flit_t       rd_flit,
  input  logic                  sink_stall,
  output logic                  pop,
  output logic                  sum_valid,
  output link_pkg::pkt_result_t result
);

  logic [link_pkg::SUM_W-1:0] acc_sum;
  logic [link_pkg::LEN_W-1:0] acc_len;
  logic [link_pkg::SUM_W-1:0] byte_ext;
  logic [link_pkg::SUM_W-1:0] sum_next;
  logic [link_pkg::LEN_W-1:0] len_next;
  logic                       pkt_end;

  // Drain one flit per cycle unless the sink holds us off.
  assign pop     = !empty && !sink_stall;
  assign pkt_end = pop && (rd_flit.op == link_pkg::FLIT_END);

  // Zero-extend the payload byte to the sum width.
  always_comb begin
    byte_ext = '0;
    byte_ext[link_pkg::DATA_W-1:0] = rd_flit.data;
  end

  assign sum_next = acc_sum + byte_ext;
  assign len_next = acc_len + 1'b1;

  // Accumulators restart after each end flit.
  always_ff @(posedge clk) begin
    if (rst) begin
      acc_sum   <= '0;
      acc_len   <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= pkt_end;
      if (pkt_end) begin
        acc_sum <= '0;
        acc_len <= '0;
      end else if (pop) begin
        acc_sum <= sum_next;
        acc_len <= len_next;
      end
    end
  end

  // Result holds the totals of the packet that ended on the last pulse.
  always_ff @(posedge clk) begin
    if (pkt_end) begin
      result.sum <= sum_next;
      result.len <= len_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/rx_fifo.sv
// Receive FIFO

`default_nettype none

module rx_fifo (
  input  logic            clk,
  input  logic            rst,
  input  logic            wr_valid,
  input  link_pkg::flit_t wr_flit,
  input  logic            pop,
  output link_pkg::flit_t rd_flit,
  output logic            empty
);

  link_pkg::flit_t                   mem [credit_pkg::MAX_CREDIT];
  logic [credit_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [credit_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [credit_pkg::CNT_W-1:0]      occ;
  logic                              full;

  assign empty   = (occ == '0);
  assign full    = (occ == credit_pkg::MAX_CNT);
  assign rd_flit = mem[rd_ptr];

  // Storage has no reset; only entries covered by occ are ever read.
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      occ    <= '0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= (wr_ptr == credit_pkg::FIFO_LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == credit_pkg::FIFO_LAST) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_valid, pop})
        2'b10:   occ <= occ + 1'b1;
        2'b01:   occ <= occ - 1'b1;
        default: occ <= occ;
      endcase
    end
  end

  // The credit loop bounds the sender to one flit per free entry.
  a_no_overflow: assert property (
    @(posedge clk) disable iff (rst)
    wr_valid |-> !full
  ) else $error("rx_fifo: write while full");

  // The consumer must only pop what is present.
  a_no_underflow: assert property (
    @(posedge clk) disable iff (rst)
    pop |-> !empty
  ) else $error("rx_fifo: pop while empty");

endmodule

`default_nettype wire

//--- hw/credit_receiver.sv
// Credit-based link receiver

`default_nettype none

module credit_receiver (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         push_valid,
  input  link_pkg::flit_t              push_flit,
  output logic                         push_credit,
  input  logic                         credit_stall,
  input  logic [credit_pkg::CNT_W-1:0] credit_initial,
  input  logic [credit_pkg::CNT_W-1:0] credit_withhold,
  input  logic                         pop_credit,
  output logic                         wr_valid,
  output link_pkg::flit_t              wr_flit,
  output logic [credit_pkg::CNT_W-1:0] credit_count,
  output logic [credit_pkg::CNT_W-1:0] credit_available
);

  credit_pkg::rx_state_e        state;
  logic [credit_pkg::CNT_W-1:0] init_cnt;
  logic [credit_pkg::CNT_W-1:0] credit_target;
  logic                         grant;

  // Flits go straight into the FIFO with no added latency.
  assign wr_valid = push_valid;
  assign wr_flit  = push_flit;

  // Number of credits the sender is allowed to hold in total.
  assign credit_target = credit_initial - credit_withhold;

  // Credit still returnable, floored at zero.
  assign credit_available = (credit_target > credit_count) ?
                            (credit_target - credit_count) : '0;

  // During init, one pulse goes out per cycle until the target is reached.
  // Afterwards a credit goes back whenever one is available, which happens
  // only after a pop has freed a FIFO entry.
  always_comb begin
    case (state)
      credit_pkg::RX_INIT: grant = (init_cnt != credit_target) && !credit_stall;
      default:             grant = (credit_available != '0) && !credit_stall;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= credit_pkg::RX_INIT;
      init_cnt <= '0;
    end else if (state == credit_pkg::RX_INIT) begin
      if (grant) begin
        init_cnt <= init_cnt + 1'b1;
      end
      if (init_cnt == credit_target) begin
        state <= credit_pkg::RX_RUN;
      end
    end
  end

  // The outstanding count already includes a pulse in the cycle it is
  // registered, so the same credit is never granted twice.
  always_ff @(posedge clk) begin
    if (rst) begin
      push_credit  <= 1'b0;
      credit_count <= '0;
    end else begin
      push_credit <= grant;
      case ({grant, pop_credit})
        2'b10:   credit_count <= credit_count + 1'b1;
        2'b01:   credit_count <= credit_count - 1'b1;
        default: credit_count <= credit_count;
      endcase
    end
  end

  // A flit on the link always carries one of the outstanding credits.
  a_push_with_credit: assert property (
    @(posedge clk) disable iff (rst)
    push_valid |-> credit_count != '0
  ) else $error("credit_receiver: flit arrived with no credit outstanding");

  // A pop frees an entry that was filled under an outstanding credit.
  a_pop_with_credit: assert property (
    @(posedge clk) disable iff (rst)
    pop_credit |-> credit_count != '0
  ) else $error("credit_receiver: pop credit with no credit outstanding");

endmodule

`default_nettype wire

//--- hw/credit_sender.sv
// Credit-based link sender

`default_nettype none

module credit_sender (
  input  logic            clk,
  input  logic            rst,
  input  logic            src_valid,
  input  link_pkg::flit_t src_flit,
  output logic            src_stall,
  input  logic            push_credit,
  output logic            push_valid,
  output link_pkg::flit_t push_flit
);

  // Credits held locally and not yet spent on a flit.
  logic [credit_pkg::CNT_W-1:0] credit_cnt;
  logic                         take;

  // The source is held off whenever no credit is left. A credit pulse
  // arriving this cycle only becomes usable on the next one.
  assign src_stall = (credit_cnt == '0);
  assign take      = src_valid && !src_stall;

  // A returned credit and a spent credit may land in the same cycle,
  // in which case the count does not move.
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_cnt <= '0;
    end else begin
      case ({push_credit, take})
        2'b10:   credit_cnt <= credit_cnt + 1'b1;
        2'b01:   credit_cnt <= credit_cnt - 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

  // The link strobe is a register, one cycle behind the source handshake.
  always_ff @(posedge clk) begin
    if (rst) begin
      push_valid <= 1'b0;
    end else begin
      push_valid <= take;
    end
  end

  // Flit payload only moves when a flit is taken.
  always_ff @(posedge clk) begin
    if (take) begin
      push_flit <= src_flit;
    end
  end

  // The receiver must never hand back more credits than the FIFO has entries.
  a_credit_cnt_max: assert property (
    @(posedge clk) disable iff (rst)
    credit_cnt <= credit_pkg::MAX_CNT
  ) else $error("credit_sender: local credit count above the credit limit");

endmodule

`default_nettype wire

//--- hw/credit_pkg.sv
// Credit control definitions

`default_nettype none

package credit_pkg;

  // Credit limit of the link. The receive FIFO has exactly this many entries.
  localparam int MAX_CREDIT = 8;

  // Credit counters must hold MAX_CREDIT itself, not just MAX_CREDIT - 1.
  localparam int CNT_W = 4;

  // Credit limit expressed at counter width, for compares against counters.
  localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(MAX_CREDIT);

  // FIFO pointer width and the index of the last entry.
  localparam int FIFO_PTR_W = $clog2(MAX_CREDIT);
  localparam logic [FIFO_PTR_W-1:0] FIFO_LAST = FIFO_PTR_W'(MAX_CREDIT - 1);

  // Credit receiver states.
  // RX_INIT hands out the initial credits, RX_RUN returns credits for pops.
  typedef enum logic {
    RX_INIT = 1'b0,
    RX_RUN  = 1'b1
  } rx_state_e;

endpackage

`default_nettype wire

//--- hw/link_pkg.sv
// Link data path definitions

`default_nettype none

package link_pkg;

  // Payload byte width carried by every flit.
  localparam int DATA_W = 8;

  // Width of the running packet sum. Sixteen bits holds the sum of
  // up to 257 full-scale bytes.
  localparam int SUM_W = 16;

  // Width of the flit count reported with each packet.
  localparam int LEN_W = 8;

  // Flit opcode. A packet is zero or more body flits followed by one end flit.
  typedef enum logic {
    FLIT_BODY = 1'b0,
    FLIT_END  = 1'b1
  } flit_op_e;

  // One flit is the unit moved across the link and stored in the receive FIFO.
  typedef struct packed {
    flit_op_e            op;
    logic [DATA_W-1:0]   data;
  } flit_t;

  // Per-packet totals produced by the packet summer.
  typedef struct packed {
    logic [SUM_W-1:0]    sum;
    logic [LEN_W-1:0]    len;
  } pkt_result_t;

endpackage

`default_nettype wire
